// ==== common/layer_norm_pkg.sv ====
package layer_norm_pkg;

    // Sample geometry
    localparam int LN_DEPTH      = 8;
    localparam int LN_DEPTH_LOG2 = 3;

    // Element format, Q4 for data, gamma and beta
    localparam int LN_WIDTH = 8;
    localparam int LN_FRAC  = 4;

    // Intermediate widths
    localparam int LN_DIFF_WIDTH  = 9;
    localparam int LN_SUM_WIDTH   = LN_WIDTH + LN_DEPTH_LOG2;
    localparam int LN_SQ_WIDTH    = 2 * LN_DIFF_WIDTH;
    localparam int LN_SQSUM_WIDTH = LN_SQ_WIDTH + LN_DEPTH_LOG2;

    // Variance in Q8, std in Q4
    localparam int LN_VAR_WIDTH = 16;
    localparam int LN_STD_WIDTH = 8;

    // Reciprocal in Q12, dividend is 2^LN_SHIFT
    localparam int LN_RECIP_WIDTH = 17;
    localparam int LN_RECIP_FRAC  = 12;
    localparam int LN_SHIFT       = LN_RECIP_FRAC + LN_FRAC;
    localparam int LN_EPSILON     = 1;

    // Triple product diff * recip * gamma with a sign bit on recip
    localparam int LN_PROD_WIDTH = LN_DIFF_WIDTH + LN_RECIP_WIDTH + 1 + LN_WIDTH;

    typedef logic signed [LN_WIDTH-1:0]       ln_elem_t;
    typedef ln_elem_t [LN_DEPTH-1:0]          ln_vec_t;
    typedef logic signed [LN_DIFF_WIDTH-1:0]  ln_diff_t;
    typedef ln_diff_t [LN_DEPTH-1:0]          ln_diff_vec_t;
    typedef logic signed [LN_SUM_WIDTH-1:0]   ln_sum_t;
    typedef logic [LN_SQSUM_WIDTH-1:0]        ln_sqsum_t;
    typedef logic signed [LN_PROD_WIDTH-1:0]  ln_prod_t;

    typedef struct packed {
        ln_vec_t data;
        ln_vec_t gamma;
        ln_vec_t beta;
    } ln_sample_t;

    typedef struct packed {
        ln_diff_t                mean;
        logic [LN_VAR_WIDTH-1:0] variance;
    } ln_stats_t;

endpackage

// ==== layer_norm/ln_stats.sv ====
`timescale 1ns/1ps

module ln_stats
(
    input  logic                         clk,
    input  logic                         reset,
    input  logic                         start,
    input  layer_norm_pkg::ln_vec_t      data,
    output logic                         done,
    output layer_norm_pkg::ln_stats_t    stats,
    output layer_norm_pkg::ln_diff_vec_t diffs
);

    // Stage one
    layer_norm_pkg::ln_sum_t      sum_c;
    layer_norm_pkg::ln_sum_t      sum_q;

    // Stage two
    layer_norm_pkg::ln_diff_t     mean_c;
    layer_norm_pkg::ln_diff_vec_t diff_c;
    logic [layer_norm_pkg::LN_SQ_WIDTH-1:0] sq_c [layer_norm_pkg::LN_DEPTH];
    layer_norm_pkg::ln_sqsum_t    sqsum_c;
    layer_norm_pkg::ln_stats_t    stats_q;
    layer_norm_pkg::ln_diff_vec_t diffs_q;

    // Stage valids, bit 0 after stage one and bit 1 after stage two
    logic [1:0] valid_q;

    // Sign-extended sum of all elements
    always_comb
    begin
        sum_c = '0;
        for (int i = 0; i < layer_norm_pkg::LN_DEPTH; i++)
        begin
            sum_c = sum_c + layer_norm_pkg::ln_sum_t'(data[i]);
        end
    end

    // Mean rounds toward minus infinity
    assign mean_c = layer_norm_pkg::ln_diff_t'(sum_q >>> layer_norm_pkg::LN_DEPTH_LOG2);

    // One squarer per element feeding the accumulation
    always_comb
    begin
        sqsum_c = '0;
        for (int i = 0; i < layer_norm_pkg::LN_DEPTH; i++)
        begin
            diff_c[i] = layer_norm_pkg::ln_diff_t'(data[i]) - mean_c;
            sq_c[i]   = diff_c[i] * diff_c[i];
            sqsum_c   = sqsum_c + layer_norm_pkg::ln_sqsum_t'(sq_c[i]);
        end
    end

    always_ff @(posedge clk)
    begin
        if (reset)
        begin
            valid_q <= 2'b00;
        end
        else
        begin
            valid_q <= {valid_q[0], start};
        end
    end

    // Data is held by the caller across both stages
    always_ff @(posedge clk)
    begin
        if (start)
        begin
            sum_q <= sum_c;
        end
        if (valid_q[0])
        begin
            diffs_q          <= diff_c;
            stats_q.mean     <= mean_c;
            // Divide by depth and keep Q8 variance
            stats_q.variance <= sqsum_c[layer_norm_pkg::LN_DEPTH_LOG2 +:
                                        layer_norm_pkg::LN_VAR_WIDTH];
        end
    end

    assign done  = valid_q[1];
    assign stats = stats_q;
    assign diffs = diffs_q;

endmodule

// ==== layer_norm/ln_isqrt.sv ====
`timescale 1ns/1ps

module ln_isqrt
(
    input  logic                                    clk,
    input  logic                                    reset,
    input  logic                                    start,
    input  logic [layer_norm_pkg::LN_VAR_WIDTH-1:0] radicand,
    output logic                                    done,
    output logic [layer_norm_pkg::LN_STD_WIDTH-1:0] root
);

    // Radicand pairs shift out of the top
    logic [layer_norm_pkg::LN_VAR_WIDTH-1:0] rad_q;
    // Remainder never exceeds twice the partial root
    logic [layer_norm_pkg::LN_STD_WIDTH:0]   rem_q;
    logic [layer_norm_pkg::LN_STD_WIDTH-1:0] root_q;
    logic [layer_norm_pkg::LN_STD_WIDTH+2:0] rem_shift;
    logic [layer_norm_pkg::LN_STD_WIDTH+2:0] trial;
    logic                                    fits;
    logic [$clog2(layer_norm_pkg::LN_STD_WIDTH+1)-1:0] count_q;
    logic                                    done_q;

    // Bring down the next two radicand bits
    assign rem_shift = {rem_q, rad_q[layer_norm_pkg::LN_VAR_WIDTH-1 -: 2]};
    // Trial subtrahend 4 * root + 1
    assign trial     = {1'b0, root_q, 2'b01};
    assign fits      = (rem_shift >= trial);

    // Iteration counter, one root bit per cycle
    always_ff @(posedge clk)
    begin
        if (reset)
        begin
            count_q <= '0;
            done_q  <= 1'b0;
        end
        else
        begin
            done_q <= 1'b0;
            if (start)
            begin
                count_q <= ($bits(count_q))'(layer_norm_pkg::LN_STD_WIDTH);
            end
            else if (count_q != '0)
            begin
                count_q <= count_q - 1'b1;
                // Last iteration lands together with done
                done_q  <= (count_q == 1);
            end
        end
    end

    always_ff @(posedge clk)
    begin
        if (start)
        begin
            rad_q  <= radicand;
            rem_q  <= '0;
            root_q <= '0;
        end
        else if (count_q != '0)
        begin
            rad_q <= rad_q << 2;
            if (fits)
            begin
                rem_q  <= (layer_norm_pkg::LN_STD_WIDTH+1)'(rem_shift - trial);
                root_q <= {root_q[layer_norm_pkg::LN_STD_WIDTH-2:0], 1'b1};
            end
            else
            begin
                rem_q  <= rem_shift[layer_norm_pkg::LN_STD_WIDTH:0];
                root_q <= {root_q[layer_norm_pkg::LN_STD_WIDTH-2:0], 1'b0};
            end
        end
    end

    // Root holds until the next start
    assign root = root_q;
    assign done = done_q;

endmodule

// ==== layer_norm/ln_recip.sv ====
`timescale 1ns/1ps

module ln_recip
(
    input  logic                                      clk,
    input  logic                                      reset,
    input  logic                                      start,
    input  logic [layer_norm_pkg::LN_STD_WIDTH-1:0]   std,
    output logic                                      done,
    output logic [layer_norm_pkg::LN_RECIP_WIDTH-1:0] recip
);

    // Divisor std + epsilon never reaches zero
    logic [layer_norm_pkg::LN_STD_WIDTH:0]     divisor_q;
    logic [layer_norm_pkg::LN_STD_WIDTH:0]     rem_q;
    logic [layer_norm_pkg::LN_STD_WIDTH+1:0]   rem_shift;
    logic [layer_norm_pkg::LN_STD_WIDTH+1:0]   rem_diff;
    logic                                      fits;
    // Dividend bits shift out the top while quotient bits enter the bottom
    logic [layer_norm_pkg::LN_RECIP_WIDTH-1:0] quot_q;
    logic [$clog2(layer_norm_pkg::LN_RECIP_WIDTH+1)-1:0] count_q;
    logic                                      done_q;

    assign rem_shift = {rem_q, quot_q[layer_norm_pkg::LN_RECIP_WIDTH-1]};
    assign rem_diff  = rem_shift - {1'b0, divisor_q};
    assign fits      = (rem_shift >= {1'b0, divisor_q});

    always_ff @(posedge clk)
    begin
        if (reset)
        begin
            count_q <= '0;
            done_q  <= 1'b0;
        end
        else
        begin
            done_q <= 1'b0;
            if (start)
            begin
                count_q <= ($bits(count_q))'(layer_norm_pkg::LN_RECIP_WIDTH);
            end
            else if (count_q != '0)
            begin
                count_q <= count_q - 1'b1;
                done_q  <= (count_q == 1);
            end
        end
    end

    always_ff @(posedge clk)
    begin
        if (start)
        begin
            divisor_q <= {1'b0, std} + (layer_norm_pkg::LN_STD_WIDTH+1)'(
                             layer_norm_pkg::LN_EPSILON);
            rem_q     <= '0;
            // Constant dividend 2^16
            quot_q    <= (layer_norm_pkg::LN_RECIP_WIDTH)'(1) << layer_norm_pkg::LN_SHIFT;
        end
        else if (count_q != '0)
        begin
            rem_q  <= fits ? rem_diff[layer_norm_pkg::LN_STD_WIDTH:0]
                           : rem_shift[layer_norm_pkg::LN_STD_WIDTH:0];
            quot_q <= {quot_q[layer_norm_pkg::LN_RECIP_WIDTH-2:0], fits};
        end
    end

    assign recip = quot_q;
    assign done  = done_q;

endmodule

// ==== layer_norm/ln_scale.sv ====
`timescale 1ns/1ps

module ln_scale
(
    input  logic                                      clk,
    input  logic                                      reset,
    input  logic                                      start,
    input  layer_norm_pkg::ln_diff_vec_t              diffs,
    input  logic [layer_norm_pkg::LN_RECIP_WIDTH-1:0] recip,
    input  layer_norm_pkg::ln_vec_t                   gamma,
    input  layer_norm_pkg::ln_vec_t                   beta,
    output logic                                      done,
    output layer_norm_pkg::ln_vec_t                   result
);

    // Full-width triple product and affine sum per element
    layer_norm_pkg::ln_prod_t prod_c [layer_norm_pkg::LN_DEPTH];
    layer_norm_pkg::ln_prod_t sum_c  [layer_norm_pkg::LN_DEPTH];
    layer_norm_pkg::ln_vec_t  sat_c;
    layer_norm_pkg::ln_vec_t  result_q;
    logic                     done_q;

    always_comb
    begin
        for (int i = 0; i < layer_norm_pkg::LN_DEPTH; i++)
        begin
            // Recip is unsigned so it widens with zeros
            prod_c[i] = layer_norm_pkg::ln_prod_t'(diffs[i])
                      * layer_norm_pkg::ln_prod_t'(recip)
                      * layer_norm_pkg::ln_prod_t'(gamma[i]);
            // Back to Q4 then add beta
            sum_c[i]  = (prod_c[i] >>> layer_norm_pkg::LN_SHIFT)
                      + layer_norm_pkg::ln_prod_t'(beta[i]);
            // In range when all bits above the element sign agree
            if (sum_c[i][layer_norm_pkg::LN_PROD_WIDTH-1:layer_norm_pkg::LN_WIDTH-1] == '0 ||
                sum_c[i][layer_norm_pkg::LN_PROD_WIDTH-1:layer_norm_pkg::LN_WIDTH-1] == '1)
            begin
                sat_c[i] = sum_c[i][layer_norm_pkg::LN_WIDTH-1:0];
            end
            else if (sum_c[i][layer_norm_pkg::LN_PROD_WIDTH-1])
            begin
                // Clip at -128
                sat_c[i] = {1'b1, {(layer_norm_pkg::LN_WIDTH-1){1'b0}}};
            end
            else
            begin
                // Clip at 127
                sat_c[i] = {1'b0, {(layer_norm_pkg::LN_WIDTH-1){1'b1}}};
            end
        end
    end

    always_ff @(posedge clk)
    begin
        if (reset)
        begin
            done_q <= 1'b0;
        end
        else
        begin
            done_q <= start;
        end
    end

    always_ff @(posedge clk)
    begin
        if (start)
        begin
            result_q <= sat_c;
        end
    end

    assign done   = done_q;
    assign result = result_q;

endmodule

// ==== rtl/layer_norm_top.sv ====
`timescale 1ns/1ps

module layer_norm_top
(
    input  logic                       clk,
    input  logic                       reset,
    input  logic                       in_valid,
    output logic                       in_ready,
    input  layer_norm_pkg::ln_sample_t in_sample,
    output logic                       out_valid,
    input  logic                       out_ready,
    output layer_norm_pkg::ln_vec_t    out_data
);

    typedef enum logic [2:0]
    {
        S_IDLE,
        S_STATS,
        S_SQRT,
        S_RECIP,
        S_SCALE,
        S_OUTPUT
    } state_t;

    state_t state_q;

    // Captured sample and held differences
    layer_norm_pkg::ln_sample_t   sample_q;
    layer_norm_pkg::ln_diff_vec_t diffs_q;
    layer_norm_pkg::ln_vec_t      out_data_q;

    // Start pulses to the four blocks
    logic stats_start_q;
    logic sqrt_start_q;
    logic recip_start_q;
    logic scale_start_q;

    // Block results
    logic                                      stats_done;
    logic                                      sqrt_done;
    logic                                      recip_done;
    logic                                      scale_done;
    layer_norm_pkg::ln_stats_t                 stats;
    layer_norm_pkg::ln_diff_vec_t              diffs;
    logic [layer_norm_pkg::LN_STD_WIDTH-1:0]   root;
    logic [layer_norm_pkg::LN_RECIP_WIDTH-1:0] recip;
    layer_norm_pkg::ln_vec_t                   result;

    // One sample in flight, so accept only when idle
    assign in_ready  = (state_q == S_IDLE);
    assign out_valid = (state_q == S_OUTPUT);
    assign out_data  = out_data_q;

    // Sequencer, each step waits on the done of the one before
    always_ff @(posedge clk)
    begin
        if (reset)
        begin
            state_q       <= S_IDLE;
            stats_start_q <= 1'b0;
            sqrt_start_q  <= 1'b0;
            recip_start_q <= 1'b0;
            scale_start_q <= 1'b0;
        end
        else
        begin
            stats_start_q <= 1'b0;
            sqrt_start_q  <= 1'b0;
            recip_start_q <= 1'b0;
            scale_start_q <= 1'b0;
            case (state_q)
                S_IDLE:
                    if (in_valid)
                    begin
                        stats_start_q <= 1'b1;
                        state_q       <= S_STATS;
                    end
                S_STATS:
                    if (stats_done)
                    begin
                        sqrt_start_q <= 1'b1;
                        state_q      <= S_SQRT;
                    end
                S_SQRT:
                    if (sqrt_done)
                    begin
                        recip_start_q <= 1'b1;
                        state_q       <= S_RECIP;
                    end
                S_RECIP:
                    if (recip_done)
                    begin
                        scale_start_q <= 1'b1;
                        state_q       <= S_SCALE;
                    end
                S_SCALE:
                    if (scale_done)
                    begin
                        state_q <= S_OUTPUT;
                    end
                // Hold the result until the consumer takes it
                S_OUTPUT:
                    if (out_ready)
                    begin
                        state_q <= S_IDLE;
                    end
                default:
                    state_q <= S_IDLE;
            endcase
        end
    end

    always_ff @(posedge clk)
    begin
        if (in_valid && in_ready)
        begin
            sample_q <= in_sample;
        end
        if (stats_done)
        begin
            diffs_q <= diffs;
        end
        if (scale_done)
        begin
            out_data_q <= result;
        end
    end

    ln_stats u_stats
    (
        .clk   (clk),
        .reset (reset),
        .start (stats_start_q),
        .data  (sample_q.data),
        .done  (stats_done),
        .stats (stats),
        .diffs (diffs)
    );

    // Variance stays registered in ln_stats while the root settles
    ln_isqrt u_isqrt
    (
        .clk      (clk),
        .reset    (reset),
        .start    (sqrt_start_q),
        .radicand (stats.variance),
        .done     (sqrt_done),
        .root     (root)
    );

    ln_recip u_recip
    (
        .clk   (clk),
        .reset (reset),
        .start (recip_start_q),
        .std   (root),
        .done  (recip_done),
        .recip (recip)
    );

    ln_scale u_scale
    (
        .clk    (clk),
        .reset  (reset),
        .start  (scale_start_q),
        .diffs  (diffs_q),
        .recip  (recip),
        .gamma  (sample_q.gamma),
        .beta   (sample_q.beta),
        .done   (scale_done),
        .result (result)
    );

endmodule

// ==== testbench/layer_norm_chk.sv ====
`timescale 1ns/1ps

module layer_norm_chk
(
    input logic                    clk,
    input logic                    reset,
    input logic                    in_ready,
    input logic                    out_valid,
    input logic                    out_ready,
    input layer_norm_pkg::ln_vec_t out_data
);

    // Stalled result keeps valid and data
    property stall_hold_p;
        @(posedge clk) disable iff (reset)
        (out_valid && !out_ready) |=> (out_valid && $stable(out_data));
    endproperty

    // Only one sample held, so ready returns only after the result was taken
    property one_sample_p;
        @(posedge clk) disable iff (reset)
        $rose(in_ready) |-> $past(out_valid && out_ready);
    endproperty

    property reset_clear_p;
        @(posedge clk)
        reset |=> !out_valid;
    endproperty

    assert property (stall_hold_p)
    else $error("out_valid or out_data moved while out_ready was low");

    assert property (one_sample_p)
    else $error("in_ready rose without an output transfer before it");

    assert property (reset_clear_p)
    else $error("out_valid high in the cycle after reset");

endmodule

bind layer_norm_top layer_norm_chk u_chk
(
    .clk       (clk),
    .reset     (reset),
    .in_ready  (in_ready),
    .out_valid (out_valid),
    .out_ready (out_ready),
    .out_data  (out_data)
);

// ==== testbench/tb_layer_norm.sv ====
`timescale 1ns/1ps

module tb_layer_norm;

    localparam int TIMEOUT_CYCLES = 200;
    localparam int RANDOM_SAMPLES = 200;
    localparam int STALL_SAMPLES  = 30;

    logic                       clk;
    logic                       reset;
    logic                       in_valid;
    logic                       in_ready;
    layer_norm_pkg::ln_sample_t in_sample;
    logic                       out_valid;
    logic                       out_ready;
    layer_norm_pkg::ln_vec_t    out_data;

    int   seed        = 40;
    int   check_count = 0;
    int   error_count = 0;
    int   fault_count = 0;
    int   sent_count  = 0;
    int   recv_count  = 0;
    logic stall_mode  = 1'b0;
    int   stall_len [STALL_SAMPLES];
    // Expected results in acceptance order
    layer_norm_pkg::ln_vec_t expected_q [$];

    layer_norm_top DUT
    (
        .clk       (clk),
        .reset     (reset),
        .in_valid  (in_valid),
        .in_ready  (in_ready),
        .in_sample (in_sample),
        .out_valid (out_valid),
        .out_ready (out_ready),
        .out_data  (out_data)
    );

    initial
    begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    task automatic check_value(input string name, input logic [63:0] actual,
                               input logic [63:0] expected);
        check_count++;
        if (actual !== expected)
        begin
            error_count++;
            $display("[ERROR] %0t %s: got 0x%0h, expected 0x%0h", $time, name, actual, expected);
        end
    endtask

    // Mean, variance, root, reciprocal, affine step and clipping
    function automatic layer_norm_pkg::ln_vec_t ref_norm(input layer_norm_pkg::ln_sample_t s);
        layer_norm_pkg::ln_vec_t res;
        int     sum;
        int     mean;
        int     diff [layer_norm_pkg::LN_DEPTH];
        int     sq_sum;
        int     variance;
        int     std_q4;
        int     recip;
        longint p;
        sum    = 0;
        sq_sum = 0;
        for (int i = 0; i < layer_norm_pkg::LN_DEPTH; i++)
            sum = sum + s.data[i];
        mean = sum >>> 3;
        for (int i = 0; i < layer_norm_pkg::LN_DEPTH; i++)
        begin
            diff[i] = s.data[i] - mean;
            sq_sum  = sq_sum + diff[i] * diff[i];
        end
        variance = sq_sum >>> 3;
        // Floor of the square root by counting up
        std_q4 = 0;
        while ((std_q4 + 1) * (std_q4 + 1) <= variance)
            std_q4++;
        recip = (1 << 16) / (std_q4 + layer_norm_pkg::LN_EPSILON);
        for (int i = 0; i < layer_norm_pkg::LN_DEPTH; i++)
        begin
            p = (longint'(diff[i]) * recip * s.gamma[i]) >>> 16;
            p = p + s.beta[i];
            if (p > 127)
                res[i] = 8'sh7f;
            else if (p < -128)
                res[i] = 8'sh80;
            else
                res[i] = p[7:0];
        end
        return res;
    endfunction

    function automatic layer_norm_pkg::ln_sample_t random_sample();
        layer_norm_pkg::ln_sample_t s;
        for (int i = 0; i < layer_norm_pkg::LN_DEPTH; i++)
        begin
            s.data[i]  = 8'($random(seed));
            s.gamma[i] = 8'($random(seed));
            s.beta[i]  = 8'($random(seed));
        end
        return s;
    endfunction

    // Offer one sample until the DUT takes it
    task automatic send_sample(input layer_norm_pkg::ln_sample_t s,
                               input layer_norm_pkg::ln_vec_t expected);
        int   cycles;
        logic accepted;
        cycles    = 0;
        accepted  = 1'b0;
        in_sample = s;
        in_valid  = 1'b1;
        while (!accepted && cycles < TIMEOUT_CYCLES)
        begin
            // Ready seen before the edge means the edge transfers
            @(negedge clk);
            accepted = in_ready;
            @(posedge clk);
            #1;
            cycles++;
        end
        in_valid = 1'b0;
        if (accepted)
        begin
            expected_q.push_back(expected);
            sent_count++;
        end
        else
        begin
            fault_count++;
            $display("Timeout: the DUT did not accept a sample within %0d cycles",
                     TIMEOUT_CYCLES);
        end
    endtask

    task automatic wait_drain();
        int cycles;
        cycles = 0;
        while (expected_q.size() != 0 && cycles < TIMEOUT_CYCLES)
        begin
            @(posedge clk);
            cycles++;
        end
        if (expected_q.size() != 0)
        begin
            fault_count++;
            $display("Timeout: %0d results never came out", expected_q.size());
        end
    endtask

    // Back-pressure, a random stall each time a result appears
    initial
    begin : drive_out_ready
        int   stall_left;
        int   stall_idx;
        logic prev_valid;
        stall_left = 0;
        stall_idx  = 0;
        prev_valid = 1'b0;
        out_ready  = 1'b1;
        forever
        begin
            @(posedge clk);
            #1;
            if (stall_mode && out_valid && !prev_valid && stall_idx < STALL_SAMPLES)
            begin
                stall_left = stall_len[stall_idx];
                stall_idx++;
            end
            prev_valid = out_valid;
            out_ready  = (stall_left == 0);
            if (stall_left > 0)
                stall_left--;
        end
    end

    // Output side sampled at the falling edge where all signals are settled
    initial
    begin : compare_outputs
        layer_norm_pkg::ln_vec_t expected;
        layer_norm_pkg::ln_vec_t held_data;
        logic                    was_stalled;
        logic                    took;
        was_stalled = 1'b0;
        took        = 1'b0;
        forever
        begin
            @(negedge clk);
            if (!reset)
            begin
                // One sample in flight, input closed while a result waits
                if (out_valid)
                    check_value("in_ready", in_ready, 0);
                else if (took)
                    check_value("in_ready", in_ready, 1);
                if (was_stalled)
                begin
                    check_value("out_valid", out_valid, 1);
                    check_value("out_data", out_data, held_data);
                end
                took        = out_valid && out_ready;
                was_stalled = out_valid && !out_ready;
                held_data   = out_data;
                if (took)
                begin
                    recv_count++;
                    if (expected_q.size() == 0)
                    begin
                        fault_count++;
                        $display("Output transfer with no sample outstanding");
                    end
                    else
                    begin
                        expected = expected_q.pop_front();
                        check_value("out_data", out_data, expected);
                    end
                end
            end
        end
    end

    initial
    begin : run_test
        layer_norm_pkg::ln_sample_t s;
        layer_norm_pkg::ln_vec_t    exp_vec;
        reset     = 1'b1;
        in_valid  = 1'b0;
        in_sample = '0;
        repeat (16) @(posedge clk);
        #1;
        reset = 1'b0;
        @(negedge clk);
        check_value("in_ready", in_ready, 1);
        check_value("out_valid", out_valid, 0);
        @(posedge clk);
        #1;

        for (int n = 0; n < RANDOM_SAMPLES; n++)
        begin
            s = random_sample();
            send_sample(s, ref_norm(s));
        end

        // Flat data gives zero variance and every output equals its beta
        s = random_sample();
        for (int i = 1; i < layer_norm_pkg::LN_DEPTH; i++)
            s.data[i] = s.data[0];
        send_sample(s, s.beta);

        // One outlier against seven minimum values, large gamma of both signs
        s.data    = {layer_norm_pkg::LN_DEPTH{8'h80}};
        s.data[0] = 8'sh7f;
        s.beta    = '0;
        s.gamma   = {layer_norm_pkg::LN_DEPTH{8'h7f}};
        exp_vec   = ref_norm(s);
        check_value("outlier_expected", $unsigned(exp_vec[0]), 8'h7f);
        send_sample(s, exp_vec);
        s.gamma   = {layer_norm_pkg::LN_DEPTH{8'h80}};
        exp_vec   = ref_norm(s);
        check_value("outlier_expected", $unsigned(exp_vec[0]), 8'h80);
        send_sample(s, exp_vec);

        // Stall lengths of 0 to 20 cycles
        for (int n = 0; n < STALL_SAMPLES; n++)
            stall_len[n] = $unsigned($random(seed)) % 21;
        stall_mode = 1'b1;
        for (int n = 0; n < STALL_SAMPLES; n++)
        begin
            s = random_sample();
            send_sample(s, ref_norm(s));
        end

        wait_drain();
        check_value("output_count", recv_count, sent_count);

        $display("Checks %0d, value errors %0d, other errors %0d",
                 check_count, error_count, fault_count);
        if (error_count == 0 && fault_count == 0)
            $display("=== PASS ===");
        else
            $display("=== FAIL ===");
        $finish;
    end

endmodule

// ==== all.f ====
common/layer_norm_pkg.sv
layer_norm/ln_stats.sv
layer_norm/ln_isqrt.sv
layer_norm/ln_recip.sv
layer_norm/ln_scale.sv
rtl/layer_norm_top.sv
testbench/layer_norm_chk.sv
testbench/tb_layer_norm.sv

// ==== Makefile ====
TOP = tb_layer_norm

.PHONY: all build run lint clean

all: run

build:
	verilator --binary --timing --assert -Wno-fatal -f all.f --top-module $(TOP)

run: build
	./obj_dir/V$(TOP) | tee sim.log
	grep -q "=== PASS ===" sim.log

lint:
	verilator --lint-only --timing -Wall -f all.f --top-module $(TOP)

clean:
	rm -rf obj_dir sim.log
